// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing -j 0
TOP       ?= tb_axis_to_axi4_wr
FILELIST  ?= src.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# pass only if the simulation printed the pass message
sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJDIR)

// File: axis_to_axi4_wr/axis_to_axi4_wr.sv
/*
 * AXI4-Stream to AXI4 write bridge, single clock axi_wr.
 * Full-width INCR bursts only; wstrb is all ones and awid is 0.
 * Load the base address with addr_load while the bridge holds no pending words.
 */
`timescale 1ns/1ps

module axis_to_axi4_wr (
    input  logic                           axi_wr,
    input  logic                           rst,
    input  logic                           s_valid,
    input  logic [axi_pkg::AXI_DATA_W-1:0] s_data,
    input  logic                           s_last,
    output logic                           s_ready,
    input  logic                           addr_load,
    input  logic [axi_pkg::AXI_ADDR_W-1:0] addr,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [axi_pkg::AXI_ADDR_W-1:0] awaddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]  awlen,
    output logic [axi_pkg::AXI_ID_W-1:0]   awid,
    output logic [2:0]                     awsize,
    output logic                           wvalid,
    input  logic                           wready,
    output logic [axi_pkg::AXI_DATA_W-1:0] wdata,
    output logic [axi_pkg::AXI_BYTES-1:0]  wstrb,
    output logic                           wlast,
    input  logic                           bvalid,
    output logic                           bready,
    input  logic [1:0]                     bresp,
    output logic                           err,
    output logic                           idle
);
    import axi_pkg::*;
    import burst_pkg::*;

    logic                  accept_en;
    logic                  push;
    logic                  pop;
    logic [AXI_DATA_W-1:0] fifo_data;
    logic                  fifo_valid;
    logic                  can_issue;
    logic                  aw_fire;
    logic                  burst_push;
    logic [BLEN_W-1:0]     burst_len;

    assign push    = s_valid && s_ready;
    assign aw_fire = awvalid && awready;
    assign awid    = '0;
    assign awsize  = 3'($clog2(AXI_BYTES));  // full-width beats
    assign wstrb   = '1;

    beat_fifo u_fifo (
        .clk(axi_wr), .rst(rst), .s_valid(s_valid), .s_data(s_data),
        .accept_en(accept_en), .s_ready(s_ready), .pop(pop),
        .fifo_data(fifo_data), .fifo_valid(fifo_valid)
    );

    burst_planner u_planner (
        .clk(axi_wr), .rst(rst), .push(push), .s_last(s_last),
        .addr_load(addr_load), .addr(addr), .can_issue(can_issue),
        .accept_en(accept_en), .awvalid(awvalid), .awready(awready),
        .awaddr(awaddr), .awlen(awlen), .burst_push(burst_push), .burst_len(burst_len)
    );

    wdata_sequencer u_wseq (
        .clk(axi_wr), .rst(rst), .burst_push(burst_push), .burst_len(burst_len),
        .fifo_valid(fifo_valid), .fifo_data(fifo_data), .pop(pop),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wlast(wlast)
    );

    resp_tracker u_resp (
        .clk(axi_wr), .rst(rst), .aw_fire(aw_fire), .bvalid(bvalid), .bresp(bresp),
        .bready(bready), .can_issue(can_issue), .err(err), .idle(idle)
    );

endmodule

// File: axis_to_axi4_wr/burst_planner.sv
/*
 * Groups accepted stream words into AXI4 INCR bursts and drives the AW channel.
 * Bursts are capped at MAX_BURST beats and never cross a PAGE_BYTES boundary.
 * After a word with s_last, intake stalls until that packet is fully assigned.
 * addr must be beat aligned and only loads while no words are unassigned.
 */
`timescale 1ns/1ps

module burst_planner (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           push,
    input  logic                           s_last,
    input  logic                           addr_load,
    input  logic [axi_pkg::AXI_ADDR_W-1:0] addr,
    input  logic                           can_issue,
    output logic                           accept_en,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [axi_pkg::AXI_ADDR_W-1:0] awaddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]  awlen,
    output logic                           burst_push,
    output logic [burst_pkg::BLEN_W-1:0]   burst_len
);
    import axi_pkg::*;
    import burst_pkg::*;

    localparam int BYTE_W     = $clog2(AXI_BYTES);
    localparam int PAGE_W     = $clog2(PAGE_BYTES);
    localparam int ROOM_W     = PAGE_W - BYTE_W + 1;
    localparam int PAGE_WORDS = PAGE_BYTES / AXI_BYTES;

    logic [CNT_W-1:0]      pend;        // accepted words not yet in a burst
    logic                  flush;       // a packet end is waiting to be flushed
    logic                  flush_next;
    logic [AXI_ADDR_W-1:0] ptr;         // address of the next unassigned word
    logic [ROOM_W-1:0]     page_room;   // words left before the page boundary
    logic [BLEN_W-1:0]     cap_len;     // min of MAX_BURST and page room
    logic [BLEN_W-1:0]     blen;        // candidate burst length
    logic                  issue;

    always_comb begin
        page_room = ROOM_W'(PAGE_WORDS) - {1'b0, ptr[PAGE_W-1:BYTE_W]};
        if (page_room < ROOM_W'(MAX_BURST)) begin
            cap_len = page_room[BLEN_W-1:0];
        end else begin
            cap_len = BLEN_W'(MAX_BURST);
        end
        // while flushing, intake is stalled, so every pending word belongs to the packet
        if (pend < CNT_W'(cap_len)) begin
            blen = pend[BLEN_W-1:0];
        end else begin
            blen = cap_len;
        end
    end

    // full-size bursts normally, any nonzero size when flushing
    assign issue = !awvalid && can_issue && (flush ? (pend != '0) : (blen == cap_len));

    always_comb begin
        if (push && s_last) begin
            flush_next = 1'b1;
        end else if (issue && flush && (CNT_W'(blen) == pend)) begin
            flush_next = 1'b0;                  // packet fully assigned
        end else begin
            flush_next = flush;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend       <= '0;
            flush      <= 1'b0;
            accept_en  <= 1'b0;
            awvalid    <= 1'b0;
            burst_push <= 1'b0;
            ptr        <= '0;
        end else begin
            pend       <= pend + CNT_W'(push) - (issue ? CNT_W'(blen) : CNT_W'(0));
            flush      <= flush_next;
            accept_en  <= !flush_next;
            burst_push <= issue;                // one pulse, same cycle awvalid rises
            if (issue) begin
                awvalid <= 1'b1;
            end else if (awready) begin
                awvalid <= 1'b0;                // handshake done
            end
            if (addr_load && (pend == '0)) begin
                ptr <= addr;
            end else if (issue) begin
                ptr <= ptr + (AXI_ADDR_W'(blen) << BYTE_W); // wraps at 19 bits
            end
        end
    end

    // AW payload, stable until the handshake
    always_ff @(posedge clk) begin
        if (issue) begin
            awaddr    <= ptr;
            awlen     <= AXI_LEN_W'(blen) - AXI_LEN_W'(1);
            burst_len <= blen;
        end
    end

endmodule

// File: axis_to_axi4_wr/resp_tracker.sv
/*
 * Counts bursts between AW handshake and write response.
 * bready is tied high; err is sticky until reset.
 */
`timescale 1ns/1ps

module resp_tracker (
    input  logic       clk,
    input  logic       rst,
    input  logic       aw_fire,
    input  logic       bvalid,
    input  logic [1:0] bresp,
    output logic       bready,
    output logic       can_issue,
    output logic       err,
    output logic       idle
);
    import axi_pkg::*;
    import burst_pkg::*;

    logic [OUTST_W-1:0] outst;      // bursts awaiting a response
    logic               b_fire;

    assign bready    = 1'b1;
    assign b_fire    = bvalid && bready;
    assign can_issue = (outst < OUTST_W'(MAX_OUTST));
    assign idle      = (outst == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            outst <= '0;
            err   <= 1'b0;
        end else begin
            case ({aw_fire, b_fire})
                2'b10:   outst <= outst + 1'b1;
                2'b01:   outst <= outst - 1'b1;
                default: outst <= outst;
            endcase
            if (b_fire && (bresp != RESP_OKAY)) begin
                err <= 1'b1;                // slverr or decerr
            end
        end
    end

endmodule

// File: axis_to_axi4_wr/wdata_sequencer.sv
/*
 * Moves buffered words onto the W channel, one burst after another.
 * Queue depth MAX_OUTST is enough as long as the slave answers a burst
 * only after its last W beat. W beats may lead the AW handshake.
 */
`timescale 1ns/1ps

module wdata_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           burst_push,
    input  logic [burst_pkg::BLEN_W-1:0]   burst_len,
    input  logic                           fifo_valid,
    input  logic [axi_pkg::AXI_DATA_W-1:0] fifo_data,
    output logic                           pop,
    output logic                           wvalid,
    input  logic                           wready,
    output logic [axi_pkg::AXI_DATA_W-1:0] wdata,
    output logic                           wlast
);
    import burst_pkg::*;

    localparam int QPTR_W = $clog2(MAX_OUTST);

    logic [BLEN_W-1:0]  len_q [MAX_OUTST];  // burst lengths in issue order
    logic [QPTR_W-1:0]  q_wr;
    logic [QPTR_W-1:0]  q_rd;
    logic [OUTST_W-1:0] q_cnt;
    logic [BLEN_W-1:0]  beat_cnt;           // beats sent in the head burst
    logic [BLEN_W-1:0]  head_len;
    logic               w_fire;
    logic               burst_done;

    assign head_len   = len_q[q_rd];
    assign wvalid     = (q_cnt != '0) && fifo_valid;
    assign wdata      = fifo_data;
    assign wlast      = (BLEN_W'(beat_cnt + 1'b1) == head_len);
    assign w_fire     = wvalid && wready;
    assign pop        = w_fire;             // fifo head advances per beat
    assign burst_done = w_fire && wlast;

    always_ff @(posedge clk) begin
        if (burst_push) begin
            len_q[q_wr] <= burst_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr     <= '0;
            q_rd     <= '0;
            q_cnt    <= '0;
            beat_cnt <= '0;
        end else begin
            if (burst_push) begin
                q_wr <= q_wr + 1'b1;
            end
            if (burst_done) begin
                q_rd     <= q_rd + 1'b1;
                beat_cnt <= '0;
            end else if (w_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            case ({burst_push, burst_done})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

endmodule

// File: common/axi_pkg.sv
/*
 * AXI4 write bus widths and response codes.
 * Data beats are always full width; narrow transfers are not supported.
 * Byte addresses are 19 bits and wrap at the top of that space.
 */
package axi_pkg;

    // address and data path
    localparam int AXI_ADDR_W = 19;            // byte address width
    localparam int AXI_DATA_W = 32;            // write data width
    localparam int AXI_BYTES  = AXI_DATA_W / 8; // bytes per beat, 4

    // burst control fields
    localparam int AXI_LEN_W  = 8;             // awlen field width
    localparam int AXI_ID_W   = 1;             // awid width, id is always 0

    // write response codes on bresp
    localparam logic [1:0] RESP_OKAY = 2'b00;  // anything else is an error

endpackage

// File: common/burst_pkg.sv
/*
 * Burst sizing for the stream to AXI4 write bridge.
 * MAX_BURST and FIFO_DEPTH must be powers of two.
 * CNT_W must hold FIFO_DEPTH, since the unassigned count never exceeds it.
 */
package burst_pkg;

    localparam int MAX_BURST  = 16;            // beats per burst, upper bound
    localparam int PAGE_BYTES = 4096;          // no burst crosses this boundary
    localparam int FIFO_DEPTH = 64;            // stream words held in the buffer
    localparam int MAX_OUTST  = 4;             // bursts issued but not yet answered

    // counter widths
    localparam int CNT_W      = 7;             // holds 0..FIFO_DEPTH
    localparam int BLEN_W     = $clog2(MAX_BURST + 1); // holds 1..MAX_BURST
    localparam int OUTST_W    = $clog2(MAX_OUTST + 1); // holds 0..MAX_OUTST

endpackage

// File: dv/clk_rst_gen.sv
/*
 * Testbench clock and reset source.
 * 8 ns clock; rst is held high for the first two rising edges
 * and drops 1 ns after the second one.
 */
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;              // 8 ns period
        end
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;                  // released with the stimulus skew
    end

endmodule

// File: dv/tb_axis_to_axi4_wr.sv
/*
 * Random stream traffic into the bridge and a random AXI write slave.
 * Inputs change 1 ns after the rising edge; seed 48 fixes the traffic.
 * The run stops at 40 cycles per word plus 2000 cycles.
 */
`timescale 1ns/1ps

module tb_axis_to_axi4_wr;
    import axi_pkg::*;

    logic clk, rst;
    logic s_valid, s_last, s_ready, addr_load;
    logic [AXI_DATA_W-1:0] s_data, wdata;
    logic [AXI_ADDR_W-1:0] addr, awaddr;
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready, err, idle;
    logic [AXI_LEN_W-1:0] awlen;
    logic [AXI_ID_W-1:0] awid;
    logic [2:0] awsize;
    logic [AXI_BYTES-1:0] wstrb;
    logic [1:0] bresp;
    int pk_len [$];
    int total = 0, limit = 0, cyc = 0, ready_pct = 100, b_pct = 100;
    int aw_done = 0, wl_done = 0, b_sent = 0;
    bit inject = 0;

    clk_rst_gen gen (.clk(clk), .rst(rst));

    axis_to_axi4_wr DUT (
        .axi_wr(clk), .rst(rst), .s_valid(s_valid), .s_data(s_data), .s_last(s_last),
        .s_ready(s_ready), .addr_load(addr_load), .addr(addr), .awvalid(awvalid),
        .awready(awready), .awaddr(awaddr), .awlen(awlen), .awid(awid), .awsize(awsize),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
        .bvalid(bvalid), .bready(bready), .bresp(bresp), .err(err), .idle(idle)
    );

    wr_checker chk (.*);

    always @(posedge clk) begin
        cyc++;
        if (awvalid && awready) aw_done++;
        if (wvalid && wready && wlast) wl_done++;  // slave may answer this burst now
        if ((limit > 0) && (cyc > limit)) begin
            $display("timeout: run exceeded %0d cycles", limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // slave ready lines and write responses
    initial begin
        forever begin
            @(posedge clk);
            #1;
            awready = ($urandom_range(99) < ready_pct);
            wready  = ($urandom_range(99) < ready_pct);
            if (bvalid) begin
                bvalid = 1'b0;          // taken, bready is always high
                b_sent++;
            end
            if ((b_sent < aw_done) && (b_sent < wl_done) && ($urandom_range(99) < b_pct)) begin
                bvalid = 1'b1;
                bresp  = inject ? 2'b10 : RESP_OKAY;
                inject = 0;
            end
        end
    end

    task automatic load_base(input logic [AXI_ADDR_W-1:0] base);
        addr_load = 1'b1;
        addr      = base;
        @(posedge clk);
        #1 addr_load = 1'b0;
    endtask

    task automatic send_packet(input int len, input int gap_max);
        bit taken;
        for (int i = 0; i < len; i++) begin
            repeat ($urandom_range(gap_max)) begin
                @(posedge clk);
                #1;
            end
            s_valid = 1'b1;
            s_data  = $urandom;
            s_last  = (i == len - 1);
            taken   = 1'b0;
            while (!taken) begin
                taken = s_ready;        // stable between edges
                @(posedge clk);
                #1;
            end
            s_valid = 1'b0;
            s_last  = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input logic [AXI_ADDR_W-1:0] base,
                            input int npk, input int rdy, input int bp, input int gap,
                            input bit bad);
        chk.start_test(name);
        ready_pct = rdy;
        b_pct     = bp;
        load_base(base);
        inject = bad;
        repeat (npk) send_packet(pk_len.pop_front(), gap);
        while (!(chk.drained() && idle && !bvalid)) begin
            @(posedge clk);
            #1;
        end
        if (bad && (err !== 1'b1)) chk.note_error("err did not rise after the error response");
        chk.end_test();
    endtask

    initial begin
        s_valid   = 0;
        s_data    = 0;
        s_last    = 0;
        addr_load = 0;
        addr      = 0;
        awready   = 0;
        wready    = 0;
        bvalid    = 0;
        bresp     = 0;
        void'($urandom(48));
        for (int i = 0; i < 15; i++) begin
            pk_len.push_back($urandom_range(70, 1));
            total += pk_len[i];
        end
        limit = 40 * total + 2000;
        wait (!rst);
        @(posedge clk);
        #1;
        run_test("aligned_flow", 19'h00100, 4, 100, 100, 0, 0);
        run_test("page_split", 19'h00FF8, 3, 90, 80, 1, 0);
        run_test("backpressure", 19'($urandom) & ~19'd3, 5, 40, 15, 3, 0);
        run_test("error_resp", 19'h40000, 3, 70, 50, 1, 1);
        $display("tests passed %0d, failed %0d, errors %0d",
                 chk.pass_cnt, chk.fail_cnt, chk.err_cnt);
        if ((chk.fail_cnt == 0) && (chk.err_cnt == 0)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: dv/wr_checker.sv
/*
 * Watches the bridge ports and checks them against a burst model.
 * Expects addr_load only while no words are waiting in the bridge.
 * All ports are sampled on the rising edge of clk.
 */
`timescale 1ns/1ps

module wr_checker (
    input logic                           clk,
    input logic                           rst,
    input logic                           s_valid,
    input logic                           s_ready,
    input logic                           s_last,
    input logic [axi_pkg::AXI_DATA_W-1:0] s_data,
    input logic                           addr_load,
    input logic [axi_pkg::AXI_ADDR_W-1:0] addr,
    input logic                           awvalid,
    input logic                           awready,
    input logic [axi_pkg::AXI_ADDR_W-1:0] awaddr,
    input logic [axi_pkg::AXI_LEN_W-1:0]  awlen,
    input logic [axi_pkg::AXI_ID_W-1:0]   awid,
    input logic [2:0]                     awsize,
    input logic                           wvalid,
    input logic                           wready,
    input logic [axi_pkg::AXI_DATA_W-1:0] wdata,
    input logic [axi_pkg::AXI_BYTES-1:0]  wstrb,
    input logic                           wlast,
    input logic                           bvalid,
    input logic                           bready,
    input logic [1:0]                     bresp,
    input logic                           err,
    input logic                           idle
);
    import axi_pkg::*;
    import burst_pkg::*;

    string                 test_name = "none";
    int                    err_cnt   = 0;       // over the whole run
    int                    test_errs = 0;
    int                    pass_cnt  = 0;
    int                    fail_cnt  = 0;
    logic [AXI_DATA_W-1:0] exp_data [$];        // accepted words in order
    logic [AXI_ADDR_W-1:0] exp_addr [$];        // model bursts for the AW side
    int                    exp_len  [$];
    int                    w_lens   [$];        // same bursts for the W side
    logic [AXI_ADDR_W-1:0] m_ptr;
    int                    m_pend;
    int                    w_beat;
    int                    outst;
    logic                  err_exp;

    task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
        err_cnt++;
        test_errs++;
    endtask

    task automatic note_error(input string msg);
        $display("test %s: %s", test_name, msg);
        err_cnt++;
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: passed", test_name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", test_name, test_errs);
        end
    endtask

    function automatic bit drained();
        return (exp_data.size() == 0) && (w_lens.size() == 0) &&
               (exp_len.size() == 0) && (m_pend == 0);
    endfunction

    // cut pending words into bursts; a flush also takes a short tail
    function automatic void plan_bursts(input bit flush);
        int room;
        int cap;
        int len;
        while (m_pend > 0) begin
            room = (PAGE_BYTES - (int'(m_ptr) % PAGE_BYTES)) / AXI_BYTES;
            cap  = (room < MAX_BURST) ? room : MAX_BURST;
            if (!flush && (m_pend < cap)) begin
                break;
            end
            len = (m_pend < cap) ? m_pend : cap;
            exp_addr.push_back(m_ptr);
            exp_len.push_back(len);
            w_lens.push_back(len);
            m_ptr  = m_ptr + AXI_ADDR_W'(len * AXI_BYTES);  // wraps at 19 bits
            m_pend = m_pend - len;
        end
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            m_ptr   = '0;
            m_pend  = 0;
            w_beat  = 0;
            outst   = 0;
            err_exp = 1'b0;
            exp_data.delete();
            exp_addr.delete();
            exp_len.delete();
            w_lens.delete();
        end else begin
            if (bready !== 1'b1) fail_value("bready", 32'd1, 32'(bready));
            // idle while no burst awaits its response
            if (idle !== (outst == 0)) fail_value("idle", 32'(outst == 0), 32'(idle));
            if (addr_load && (m_pend == 0)) begin
                m_ptr = addr;
            end
            if (s_valid && s_ready) begin
                exp_data.push_back(s_data);
                m_pend++;
                plan_bursts(s_last);
            end
            if (awvalid && awready) begin
                outst++;
                if (exp_len.size() == 0) begin
                    note_error("AW handshake with no burst expected");
                end else begin
                    if (awaddr !== exp_addr[0]) begin
                        fail_value("awaddr", 32'(exp_addr[0]), 32'(awaddr));
                    end
                    if (awlen !== AXI_LEN_W'(exp_len[0] - 1)) begin
                        fail_value("awlen", 32'(exp_len[0] - 1), 32'(awlen));
                    end
                    if (awsize !== 3'd2) fail_value("awsize", 32'd2, 32'(awsize));
                    if (awid !== '0) fail_value("awid", 32'd0, 32'(awid));
                    void'(exp_addr.pop_front());
                    void'(exp_len.pop_front());
                end
                if (outst > MAX_OUTST) begin
                    note_error("more than four bursts outstanding");
                end
            end
            if (wvalid && wready) begin
                if ((exp_data.size() == 0) || (w_lens.size() == 0)) begin
                    note_error("W beat with no word or burst expected");
                end else begin
                    if (wdata !== exp_data[0]) fail_value("wdata", exp_data[0], wdata);
                    if (wstrb !== '1) fail_value("wstrb", 32'hF, 32'(wstrb));
                    if (wlast !== (w_beat == w_lens[0] - 1)) begin
                        fail_value("wlast", 32'(w_beat == w_lens[0] - 1), 32'(wlast));
                    end
                    void'(exp_data.pop_front());
                    w_beat++;
                    if (w_beat == w_lens[0]) begin
                        w_beat = 0;
                        void'(w_lens.pop_front());
                    end
                end
            end
            // err follows a bad response one cycle later and never clears
            if (err !== err_exp) fail_value("err", 32'(err_exp), 32'(err));
            if (bvalid && bready) begin
                outst--;
                if (bresp != RESP_OKAY) err_exp = 1'b1;
            end
        end
    end

endmodule

// File: hdl/beat_fifo.sv
/*
 * Stream word buffer with first-word-fall-through output.
 * s_ready combines not-full with the planner's accept_en.
 * Depth must be a power of two; pop is ignored while empty.
 */
`timescale 1ns/1ps

module beat_fifo (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           s_valid,
    input  logic [axi_pkg::AXI_DATA_W-1:0] s_data,
    input  logic                           accept_en,
    output logic                           s_ready,
    input  logic                           pop,
    output logic [axi_pkg::AXI_DATA_W-1:0] fifo_data,
    output logic                           fifo_valid
);
    import axi_pkg::*;
    import burst_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [AXI_DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  full;
    logic                  push_en;
    logic                  pop_en;

    assign full       = (count == CNT_W'(FIFO_DEPTH));
    assign s_ready    = !full && accept_en;
    assign push_en    = s_valid && s_ready;     // stream handshake
    assign fifo_valid = (count != '0);
    assign pop_en     = pop && fifo_valid;
    assign fifo_data  = mem[rd_ptr];            // head word shows without a read cycle

    // storage, written on every accepted word
    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[wr_ptr] <= s_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;        // wraps at depth
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

endmodule

// File: src.f
common/axi_pkg.sv
common/burst_pkg.sv
hdl/beat_fifo.sv
axis_to_axi4_wr/burst_planner.sv
axis_to_axi4_wr/wdata_sequencer.sv
axis_to_axi4_wr/resp_tracker.sv
axis_to_axi4_wr/axis_to_axi4_wr.sv
dv/clk_rst_gen.sv
dv/wr_checker.sv
dv/tb_axis_to_axi4_wr.sv
